/* Bender.yml */
package:
  name: vc_map

sources:
  - hw/vc_map_pkg.sv
  - hw/mem_req_if.sv
  - hw/vc_addr_hash.sv
  - hw/vc_map_ctrl.sv
  - hw/vc_map_stage.sv
  - hw/vc_map_top.sv
  - target: simulation
    files:
      - sim/vc_map_assert.sv
      - sim/vc_map_tb.sv

/* hw/mem_req_if.sv */
// ==============================
// Memory request interface
// Valid/ready request channel with a header and
// a payload whose type is set per stream
// ==============================

`timescale 1ns/10ps

interface mem_req_if
#(
    parameter type payload_t = logic
);

    // A transfer happens on a clock edge where valid and ready are both high
    logic                 valid;
    logic                 ready;
    vc_map_pkg::req_hdr_t hdr;
    payload_t             payload;

    // Producer side, holds valid, hdr and payload until the transfer
    modport source
    (
        output valid,
        output hdr,
        output payload,
        input  ready
    );

    // Consumer side
    modport sink
    (
        input  valid,
        input  hdr,
        input  payload,
        output ready
    );

endinterface

/* hw/vc_addr_hash.sv */
// ==============================
// Address hash
// Swizzles a cache-line address and folds it through
// CRC-32 into a 6-bit mapping index
// ==============================

`timescale 1ns/10ps

module vc_addr_hash
(
    input  logic [vc_map_pkg::addr_w-1:0] addr,
    output vc_map_pkg::ratio_t            idx
);

    // The two low line bits are covered by multi-line requests
    logic [31:0] a;
    // Swizzled word fed to the CRC
    logic [31:0] swz;
    // CRC remainder after all 32 bits are shifted in
    logic [31:0] crc;

    // Dropping bits 1..0 keeps every line of a 2 or 4 line request on
    // the same channel as its first line
    assign a = addr[33:2];

    // Bits 4 and 5 of the input barely reach the low six bits of the
    // CRC, so swap them with high address bits that matter less
    assign swz = {a[29:4], a[31:30], a[3:0]};

    // Serial CRC-32 with zero start value and no final inversion,
    // MSB first, unrolled by the loop into plain XOR logic
    always_comb
    begin : crc_fold
        logic fb;

        crc = '0;
        for (int i = 31; i >= 0; i--)
        begin
            fb = crc[31] ^ swz[i];
            crc = {crc[30:0], 1'b0};
            if (fb)
            begin
                crc = crc ^ vc_map_pkg::crc32_poly;
            end
        end
    end

    // Only the low bits index the 64-entry ratio range
    assign idx = crc[vc_map_pkg::ratio_w-1:0];

endmodule

/* hw/vc_map_ctrl.sv */
// ==============================
// Mapping control register
// Decodes the control word on a config strobe and
// holds the active mapping configuration
// ==============================

`timescale 1ns/10ps

module vc_map_ctrl
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_valid,
    input  logic [vc_map_pkg::cfg_w-1:0] cfg_word,
    output vc_map_pkg::map_cfg_t         cfg
);

    // Configuration decoded from the incoming word
    vc_map_pkg::map_cfg_t cfg_next;

    // Field extraction from the control word
    always_comb
    begin
        cfg_next.enable = cfg_word[vc_map_pkg::cfg_bit_enable];
        cfg_next.map_all = cfg_word[vc_map_pkg::cfg_bit_map_all];
        cfg_next.always_vl0 = cfg_word[vc_map_pkg::cfg_bit_always_vl0];

        // Without the override bit the word's ratio field is ignored
        if (cfg_word[vc_map_pkg::cfg_bit_override])
        begin
            cfg_next.ratio = cfg_word[vc_map_pkg::cfg_ratio_lsb +: vc_map_pkg::ratio_w];
        end
        else
        begin
            cfg_next.ratio = vc_map_pkg::ratio_t'(vc_map_pkg::ratio_default);
        end
    end

    // ==============================
    // Configuration register
    // ==============================

    // Mapping comes up enabled with the default ratio and explicit
    // channels left alone
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg.enable <= 1'b1;
            cfg.map_all <= 1'b0;
            cfg.ratio <= vc_map_pkg::ratio_t'(vc_map_pkg::ratio_default);
            cfg.always_vl0 <= 1'b0;
        end
        else if (cfg_valid)
        begin
            // The new setting is seen by the stages one cycle later
            cfg <= cfg_next;
        end
    end

endmodule

/* hw/vc_map_pkg.sv */
// ==============================
// VC mapper package
// Widths, channel and length encodings, the request header
// and the mapping configuration shared by all mapper blocks
// ==============================

package vc_map_pkg;

    // ==============================
    // Widths and constants
    // ==============================

    // Cache-line address width
    localparam int addr_w = 42;
    // Request tag width
    localparam int mdata_w = 16;
    // Write data width carried on the write stream
    localparam int data_w = 64;
    // Ratio and hash index width, the share is counted in 64ths
    localparam int ratio_w = 6;
    // Share of mapped requests sent to vl0 when no override is written
    localparam int ratio_default = 16;

    // CRC-32 generator polynomial, non-reflected form
    localparam logic [31:0] crc32_poly = 32'h04c11db7;

    // Control word layout
    localparam int cfg_w = 10;
    localparam int cfg_bit_enable = 0;
    localparam int cfg_bit_map_all = 1;
    localparam int cfg_bit_override = 2;
    // Ratio field is ratio_w bits starting here
    localparam int cfg_ratio_lsb = 3;
    localparam int cfg_bit_always_vl0 = 9;

    // ==============================
    // Types
    // ==============================

    // Channel encoding, va asks the mapper to pick a physical channel
    typedef enum logic [1:0] {va = 2'd0, vl0 = 2'd1, vh0 = 2'd2, vh1 = 2'd3} vc_t;

    // Request length in cache lines, 3 lines is not legal
    typedef enum logic [1:0] {len1 = 2'd0, len2 = 2'd1, len4 = 2'd3} cl_len_t;

    typedef logic [ratio_w-1:0] ratio_t;

    // Header fields the mapper looks at, 47 bits
    typedef struct packed {
        logic [addr_w-1:0] addr;
        cl_len_t           cl_len;
        vc_t               vc;
        logic              map_va;
    } req_hdr_t;

    // Current mapping configuration, 9 bits
    typedef struct packed {
        logic   enable;
        logic   map_all;
        ratio_t ratio;
        logic   always_vl0;
    } map_cfg_t;

    typedef struct packed {
        logic [mdata_w-1:0] mdata;
    } rd_payload_t;

    typedef struct packed {
        logic [mdata_w-1:0] mdata;
        logic [data_w-1:0]  data;
    } wr_payload_t;

endpackage

/* hw/vc_map_stage.sv */
// ==============================
// Mapping pipeline stage
// Two-register valid/ready pipeline that hashes the request
// address and rewrites the channel of qualifying requests
// ==============================

`timescale 1ns/10ps

module vc_map_stage
#(
    parameter type payload_t = logic
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  vc_map_pkg::map_cfg_t cfg,
    mem_req_if.sink              req_in,
    mem_req_if.source            req_out
);

    // Stage one holds the request and the index of its address
    logic                 s1_valid;
    vc_map_pkg::req_hdr_t s1_hdr;
    payload_t             s1_payload;
    vc_map_pkg::ratio_t   s1_idx;

    // Stage two holds the request with its final channel
    logic                 s2_valid;
    vc_map_pkg::req_hdr_t s2_hdr;
    payload_t             s2_payload;

    // Hash of the address presented at the input
    vc_map_pkg::ratio_t in_idx;

    // Each register loads when the one after it is empty or draining
    logic s1_advance;
    logic s2_advance;

    // Channel rewrite for the request in stage one
    logic                 qualifies;
    vc_map_pkg::vc_t      mapped_vc;
    vc_map_pkg::req_hdr_t mapped_hdr;

    vc_addr_hash hash_i
    (
        .addr (req_in.hdr.addr),
        .idx  (in_idx)
    );

    // ==============================
    // Flow control
    // ==============================

    assign s2_advance = !s2_valid || req_out.ready;
    assign s1_advance = !s1_valid || s2_advance;

    // A stall fills stage two first, then stage one, and only then
    // drops the input ready
    assign req_in.ready = s1_advance;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (s1_advance)
            begin
                s1_valid <= req_in.valid;
            end
            if (s2_advance)
            begin
                s2_valid <= s1_valid;
            end
        end
    end

    // ==============================
    // Channel mapping
    // ==============================

    always_comb
    begin
        // Mapping applies to va requests, or to every channel in map_all mode
        qualifies = cfg.enable && s1_hdr.map_va &&
                    ((s1_hdr.vc == vc_map_pkg::va) || cfg.map_all);

        // Indexes below the ratio go to vl0, the rest split evenly on bit 0
        if ((s1_idx < cfg.ratio) || cfg.always_vl0)
        begin
            mapped_vc = vc_map_pkg::vl0;
        end
        else if (s1_idx[0])
        begin
            mapped_vc = vc_map_pkg::vh0;
        end
        else
        begin
            mapped_vc = vc_map_pkg::vh1;
        end

        mapped_hdr = s1_hdr;
        if (qualifies)
        begin
            mapped_hdr.vc = mapped_vc;
        end
    end

    // Data registers move with their stage and carry no reset
    always_ff @(posedge clk)
    begin
        if (s1_advance)
        begin
            s1_hdr <= req_in.hdr;
            s1_payload <= req_in.payload;
            s1_idx <= in_idx;
        end
        if (s2_advance)
        begin
            s2_hdr <= mapped_hdr;
            s2_payload <= s1_payload;
        end
    end

    assign req_out.valid = s2_valid;
    assign req_out.hdr = s2_hdr;
    assign req_out.payload = s2_payload;

endmodule

/* hw/vc_map_top.sv */
// ==============================
// VC mapper top level
// Read and write request streams mapped onto physical
// channels under one shared control register
// ==============================

`timescale 1ns/10ps

module vc_map_top
(
    input  logic                           clk,
    input  logic                           reset,

    // Control word strobe
    input  logic                           cfg_valid,
    input  logic [vc_map_pkg::cfg_w-1:0]   cfg_word,

    // Read requests in
    input  logic                           rd_in_valid,
    output logic                           rd_in_ready,
    input  logic [vc_map_pkg::addr_w-1:0]  rd_in_addr,
    input  vc_map_pkg::cl_len_t            rd_in_len,
    input  vc_map_pkg::vc_t                rd_in_vc,
    input  logic                           rd_in_map_va,
    input  logic [vc_map_pkg::mdata_w-1:0] rd_in_mdata,

    // Read requests out
    output logic                           rd_out_valid,
    input  logic                           rd_out_ready,
    output logic [vc_map_pkg::addr_w-1:0]  rd_out_addr,
    output vc_map_pkg::cl_len_t            rd_out_len,
    output vc_map_pkg::vc_t                rd_out_vc,
    output logic                           rd_out_map_va,
    output logic [vc_map_pkg::mdata_w-1:0] rd_out_mdata,

    // Write requests in
    input  logic                           wr_in_valid,
    output logic                           wr_in_ready,
    input  logic [vc_map_pkg::addr_w-1:0]  wr_in_addr,
    input  vc_map_pkg::cl_len_t            wr_in_len,
    input  vc_map_pkg::vc_t                wr_in_vc,
    input  logic                           wr_in_map_va,
    input  logic [vc_map_pkg::mdata_w-1:0] wr_in_mdata,
    input  logic [vc_map_pkg::data_w-1:0]  wr_in_data,

    // Write requests out
    output logic                           wr_out_valid,
    input  logic                           wr_out_ready,
    output logic [vc_map_pkg::addr_w-1:0]  wr_out_addr,
    output vc_map_pkg::cl_len_t            wr_out_len,
    output vc_map_pkg::vc_t                wr_out_vc,
    output logic                           wr_out_map_va,
    output logic [vc_map_pkg::mdata_w-1:0] wr_out_mdata,
    output logic [vc_map_pkg::data_w-1:0]  wr_out_data
);

    vc_map_pkg::map_cfg_t cfg;

    mem_req_if #(.payload_t(vc_map_pkg::rd_payload_t)) rd_in ();
    mem_req_if #(.payload_t(vc_map_pkg::rd_payload_t)) rd_out ();
    mem_req_if #(.payload_t(vc_map_pkg::wr_payload_t)) wr_in ();
    mem_req_if #(.payload_t(vc_map_pkg::wr_payload_t)) wr_out ();

    // ==============================
    // Port to interface wiring
    // ==============================

    assign rd_in.valid = rd_in_valid;
    assign rd_in.hdr = '{addr: rd_in_addr, cl_len: rd_in_len, vc: rd_in_vc,
                         map_va: rd_in_map_va};
    assign rd_in.payload.mdata = rd_in_mdata;
    assign rd_in_ready = rd_in.ready;

    assign rd_out_valid = rd_out.valid;
    assign rd_out_addr = rd_out.hdr.addr;
    assign rd_out_len = rd_out.hdr.cl_len;
    assign rd_out_vc = rd_out.hdr.vc;
    assign rd_out_map_va = rd_out.hdr.map_va;
    assign rd_out_mdata = rd_out.payload.mdata;
    assign rd_out.ready = rd_out_ready;

    // Write data rides along untouched with the tag
    assign wr_in.valid = wr_in_valid;
    assign wr_in.hdr = '{addr: wr_in_addr, cl_len: wr_in_len, vc: wr_in_vc,
                         map_va: wr_in_map_va};
    assign wr_in.payload = '{mdata: wr_in_mdata, data: wr_in_data};
    assign wr_in_ready = wr_in.ready;

    assign wr_out_valid = wr_out.valid;
    assign wr_out_addr = wr_out.hdr.addr;
    assign wr_out_len = wr_out.hdr.cl_len;
    assign wr_out_vc = wr_out.hdr.vc;
    assign wr_out_map_va = wr_out.hdr.map_va;
    assign wr_out_mdata = wr_out.payload.mdata;
    assign wr_out_data = wr_out.payload.data;
    assign wr_out.ready = wr_out_ready;

    // ==============================
    // Control and the two streams
    // ==============================

    vc_map_ctrl ctrl_i
    (
        .clk       (clk),
        .reset     (reset),
        .cfg_valid (cfg_valid),
        .cfg_word  (cfg_word),
        .cfg       (cfg)
    );

    // Both streams see the same configuration but never stall each other
    vc_map_stage #(.payload_t(vc_map_pkg::rd_payload_t)) rd_stage_i
    (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .req_in  (rd_in),
        .req_out (rd_out)
    );

    vc_map_stage #(.payload_t(vc_map_pkg::wr_payload_t)) wr_stage_i
    (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .req_in  (wr_in),
        .req_out (wr_out)
    );

endmodule

/* list.f */
hw/vc_map_pkg.sv
hw/mem_req_if.sv
hw/vc_addr_hash.sv
hw/vc_map_ctrl.sv
hw/vc_map_stage.sv
hw/vc_map_top.sv
sim/vc_map_assert.sv
sim/vc_map_tb.sv

/* sim/vc_map_assert.sv */
// ==============================
// Mapping stage checks
// Handshake and reset properties of the stage output
// ==============================

`timescale 1ns/10ps

module vc_map_assert
(
    input logic                 clk,
    input logic                 reset,
    input vc_map_pkg::map_cfg_t cfg,
    input logic                 out_valid,
    input logic                 out_ready,
    input vc_map_pkg::req_hdr_t out_hdr
);

    // Output is empty right after reset
    reset_empty: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("Output valid high after reset");

    // A stalled request holds until the sink takes it
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_hdr))
        else $error("Output request changed while stalled");

    // In map_all mode a mappable request always leaves on a physical channel
    no_va_out: assert property (@(posedge clk) disable iff (reset)
        out_valid && cfg.enable && out_hdr.map_va && cfg.map_all |->
        out_hdr.vc != vc_map_pkg::va)
        else $error("Channel va left the mapper in map_all mode");

endmodule

bind vc_map_stage vc_map_assert stage_assert_i
(
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .out_valid (s2_valid),
    .out_ready (req_out.ready),
    .out_hdr   (s2_hdr)
);

/* sim/vc_map_tb.sv */
// ==============================
// VC mapper testbench
// Random read and write requests checked against a
// reference model of the address hash and channel rule
// ==============================

`timescale 1ns/10ps

module vc_map_tb;

    typedef struct packed {
        vc_map_pkg::req_hdr_t             hdr;
        logic [vc_map_pkg::mdata_w-1:0]   mdata;
        logic [vc_map_pkg::data_w-1:0]    data;
        logic [31:0]                      cyc;
    } req_t;

    localparam int cycle_limit = 20000;

    logic clk = 1'b0;
    logic reset, cfg_valid;
    logic [vc_map_pkg::cfg_w-1:0] cfg_word;
    logic rd_in_valid, rd_in_ready, rd_in_map_va, rd_out_valid, rd_out_ready, rd_out_map_va;
    logic wr_in_valid, wr_in_ready, wr_in_map_va, wr_out_valid, wr_out_ready, wr_out_map_va;
    logic [vc_map_pkg::addr_w-1:0] rd_in_addr, rd_out_addr, wr_in_addr, wr_out_addr;
    vc_map_pkg::cl_len_t rd_in_len, rd_out_len, wr_in_len, wr_out_len;
    vc_map_pkg::vc_t rd_in_vc, rd_out_vc, wr_in_vc, wr_out_vc;
    logic [vc_map_pkg::mdata_w-1:0] rd_in_mdata, rd_out_mdata, wr_in_mdata, wr_out_mdata;
    logic [vc_map_pkg::data_w-1:0] wr_in_data, wr_out_data;

    // Stream 0 is reads, stream 1 is writes
    req_t stim_q[2][$];
    req_t exp_q[2][$];
    logic in_fire[2] = '{1'b0, 1'b0};
    int out_count[2];
    vc_map_pkg::vc_t group_vc[2];
    int cycles = 0;
    int valid_pct, ready_pct;
    // 0 no extra rule, 1 never vl0, 2 always vl0
    int vc_rule = 0;
    logic group_mode = 1'b0;
    logic lat_mode = 1'b0;

    // Reference copy of the mapping configuration
    logic m_enable = 1'b1;
    logic m_map_all = 1'b0;
    logic m_always = 1'b0;
    logic [5:0] m_ratio = 6'd16;

    vc_map_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp)
        else
            fail_stop($sformatf("Error: time %0t signal %s got %0h expected %0h",
                                $time, name, got, exp));
    endtask

    // CRC as the remainder of the swizzled word times x^32, divided by the polynomial
    function automatic logic [5:0] model_index(input logic [41:0] addr);
        logic [31:0] w;
        logic [63:0] r;
        w = addr[33:2];
        r = {w[29:4], w[31:30], w[3:0], 32'h0};
        for (int b = 63; b >= 32; b--)
        begin
            if (r[b])
            begin
                r[b -: 33] = r[b -: 33] ^ {1'b1, 32'h04c11db7};
            end
        end
        return r[5:0];
    endfunction

    function automatic vc_map_pkg::vc_t model_vc(input vc_map_pkg::req_hdr_t h);
        logic [5:0] idx;
        idx = model_index(h.addr);
        if (!(m_enable && h.map_va && (h.vc == vc_map_pkg::va || m_map_all)))
            return h.vc;
        if (idx < m_ratio || m_always)
            return vc_map_pkg::vl0;
        return idx[0] ? vc_map_pkg::vh0 : vc_map_pkg::vh1;
    endfunction

    task automatic check_transfer(input int s, input req_t got);
        req_t e;
        string p;
        p = (s == 0) ? "rd_out_" : "wr_out_";
        if (exp_q[s].size() == 0)
        begin
            fail_stop($sformatf("Output transfer on %s with no request outstanding", p));
        end
        else
        begin
            e = exp_q[s].pop_front();
            compare_field({p, "addr"}, 64'(got.hdr.addr), 64'(e.hdr.addr));
            compare_field({p, "len"}, 64'(got.hdr.cl_len), 64'(e.hdr.cl_len));
            compare_field({p, "vc"}, 64'(got.hdr.vc), 64'(e.hdr.vc));
            compare_field({p, "map_va"}, 64'(got.hdr.map_va), 64'(e.hdr.map_va));
            compare_field({p, "mdata"}, 64'(got.mdata), 64'(e.mdata));
            compare_field({p, "data"}, got.data, e.data);
            // Lines of one group must share the channel of the first line
            if (group_mode && out_count[s] % 4 == 0)
                group_vc[s] = got.hdr.vc;
            else if (group_mode)
                compare_field({p, "vc"}, 64'(got.hdr.vc), 64'(group_vc[s]));
            out_count[s]++;
            if (vc_rule == 1)
                assert (got.hdr.vc != vc_map_pkg::vl0)
                else fail_stop("A request went to vl0 with a ratio of 0");
            if (vc_rule == 2)
                compare_field({p, "vc"}, 64'(got.hdr.vc), 64'(vc_map_pkg::vl0));
            if (lat_mode)
                compare_field({p, "latency"}, 64'(cycles - e.cyc), 64'd2);
        end
    endtask

    // Handshakes are sampled at the rising edge, before the DUT registers update
    always @(posedge clk)
    begin : monitor
        req_t r;
        cycles++;
        if (cycles >= cycle_limit)
            fail_stop("Timeout, the run went past its cycle limit");
        in_fire[0] = !reset && rd_in_valid && rd_in_ready;
        in_fire[1] = !reset && wr_in_valid && wr_in_ready;
        if (lat_mode && ((rd_in_valid && !rd_in_ready) || (wr_in_valid && !wr_in_ready)))
            fail_stop("Input ready dropped with no back-pressure");
        if (in_fire[0])
        begin
            r = '{hdr: '{rd_in_addr, rd_in_len, rd_in_vc, rd_in_map_va},
                  mdata: rd_in_mdata, data: '0, cyc: cycles};
            r.hdr.vc = model_vc(r.hdr);
            exp_q[0].push_back(r);
        end
        if (in_fire[1])
        begin
            r = '{hdr: '{wr_in_addr, wr_in_len, wr_in_vc, wr_in_map_va},
                  mdata: wr_in_mdata, data: wr_in_data, cyc: cycles};
            r.hdr.vc = model_vc(r.hdr);
            exp_q[1].push_back(r);
        end
        if (!reset && rd_out_valid && rd_out_ready)
            check_transfer(0, '{hdr: '{rd_out_addr, rd_out_len, rd_out_vc, rd_out_map_va},
                                mdata: rd_out_mdata, data: '0, cyc: '0});
        if (!reset && wr_out_valid && wr_out_ready)
            check_transfer(1, '{hdr: '{wr_out_addr, wr_out_len, wr_out_vc, wr_out_map_va},
                                mdata: wr_out_mdata, data: wr_out_data, cyc: '0});
    end

    // ==============================
    // Stimulus
    // ==============================

    // Mode 0 random, mode 1 mappable va, mode 2 groups of four lines
    task automatic make_requests(input int n, input int mode);
        req_t r;
        logic [63:0] rnd;
        logic [41:0] base;
        for (int s = 0; s < 2; s++)
        begin
            for (int i = 0; i < n; i++)
            begin
                rnd = {$urandom(), $urandom()};
                r.hdr.addr = rnd[41:0];
                r.hdr.cl_len = ($urandom_range(2) == 0) ? vc_map_pkg::len1 :
                               ($urandom_range(1) == 0) ? vc_map_pkg::len2 : vc_map_pkg::len4;
                r.hdr.vc = vc_map_pkg::vc_t'($urandom_range(3));
                r.hdr.map_va = $urandom_range(1);
                if (mode != 0)
                begin
                    r.hdr.vc = vc_map_pkg::va;
                    r.hdr.map_va = 1'b1;
                end
                if (mode == 2 && i % 4 == 0)
                    base = {rnd[41:2], 2'b00};
                if (mode == 2)
                begin
                    r.hdr.addr = base | 42'(i % 4);
                    r.hdr.cl_len = (i % 4 == 1) ? vc_map_pkg::len2 :
                                   (i % 4 == 2) ? vc_map_pkg::len4 : vc_map_pkg::len1;
                end
                r.mdata = $urandom();
                r.data = (s == 1) ? {$urandom(), $urandom()} : '0;
                r.cyc = '0;
                stim_q[s].push_back(r);
            end
        end
    endtask

    task automatic drive_cycle();
        req_t r;
        @(negedge clk);
        if (!rd_in_valid || in_fire[0])
        begin
            rd_in_valid = 1'b0;
            if (stim_q[0].size() > 0 && $urandom_range(99) < valid_pct)
            begin
                r = stim_q[0].pop_front();
                rd_in_addr = r.hdr.addr;
                rd_in_len = r.hdr.cl_len;
                rd_in_vc = r.hdr.vc;
                rd_in_map_va = r.hdr.map_va;
                rd_in_mdata = r.mdata;
                rd_in_valid = 1'b1;
            end
        end
        if (!wr_in_valid || in_fire[1])
        begin
            wr_in_valid = 1'b0;
            if (stim_q[1].size() > 0 && $urandom_range(99) < valid_pct)
            begin
                r = stim_q[1].pop_front();
                wr_in_addr = r.hdr.addr;
                wr_in_len = r.hdr.cl_len;
                wr_in_vc = r.hdr.vc;
                wr_in_map_va = r.hdr.map_va;
                {wr_in_mdata, wr_in_data} = {r.mdata, r.data};
                wr_in_valid = 1'b1;
            end
        end
        rd_out_ready = $urandom_range(99) < ready_pct;
        wr_out_ready = $urandom_range(99) < ready_pct;
    endtask

    task automatic run_all();
        while (stim_q[0].size() + stim_q[1].size() + exp_q[0].size() + exp_q[1].size() > 0
               || rd_in_valid || wr_in_valid)
            drive_cycle();
    endtask

    // Written only while both streams are idle, the model follows the word layout
    task automatic write_cfg(input logic [9:0] word);
        @(negedge clk);
        cfg_word = word;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        m_enable = word[0];
        m_map_all = word[1];
        m_ratio = word[2] ? word[8:3] : 6'd16;
        m_always = word[9];
    endtask

    initial
    begin
        void'($urandom(84830));
        {reset, cfg_valid, cfg_word} = {1'b1, 1'b0, 10'h0};
        {rd_in_valid, rd_in_addr, rd_in_map_va, rd_in_mdata} = '0;
        rd_in_len = vc_map_pkg::len1;
        rd_in_vc = vc_map_pkg::va;
        {wr_in_valid, wr_in_addr, wr_in_map_va, wr_in_mdata} = '0;
        wr_in_len = vc_map_pkg::len1;
        wr_in_vc = vc_map_pkg::va;
        {wr_in_data, rd_out_ready, wr_out_ready} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Both streams accept from the first cycle out of reset
        assert (rd_in_ready && wr_in_ready)
        else fail_stop("Input ready was low in the first cycle after reset");
        {valid_pct, ready_pct} = {32'd70, 32'd70};
        // Defaults after reset
        make_requests(100, 1);
        run_all();
        // Random control words, the second one with enable and map_all set
        write_cfg(10'($urandom_range(1023)));
        make_requests(100, 0);
        run_all();
        write_cfg(10'($urandom_range(1023)) | 10'h003);
        make_requests(100, 0);
        run_all();
        // Extreme ratios and force mode
        write_cfg(10'h005);
        vc_rule = 1;
        make_requests(40, 1);
        run_all();
        vc_rule = 0;
        write_cfg(10'h005 | (10'd63 << 3));
        make_requests(40, 1);
        run_all();
        write_cfg(10'h201);
        vc_rule = 2;
        make_requests(40, 1);
        run_all();
        vc_rule = 0;
        // Lines of one request group land together
        write_cfg(10'h001);
        out_count = '{0, 0};
        group_mode = 1'b1;
        make_requests(120, 2);
        run_all();
        group_mode = 1'b0;
        // Back-pressure on both streams, then a full-rate run
        {valid_pct, ready_pct} = {32'd60, 32'd40};
        make_requests(40, 0);
        run_all();
        {valid_pct, ready_pct} = {32'd100, 32'd100};
        lat_mode = 1'b1;
        make_requests(20, 0);
        run_all();
        lat_mode = 1'b0;
        // Every request has left, so nothing may still be offered at the outputs
        if (rd_out_valid || wr_out_valid)
        begin
            fail_stop("An output was still valid after the last request had left");
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule
